/* hdl/m6502_isa_pkg.sv */
package m6502_isa_pkg;

   // Opcode bytes of the supported instructions. Group one is laid out as aaabbb01
   typedef enum logic [7:0] {
      ORA_IND_X = 8'h01, ORA_ZP   = 8'h05, ORA_IMM   = 8'h09, ORA_ABS   = 8'h0D,
      ORA_IND_Y = 8'h11, ORA_ZP_X = 8'h15, ORA_ABS_Y = 8'h19, ORA_ABS_X = 8'h1D,
      AND_IND_X = 8'h21, AND_ZP   = 8'h25, AND_IMM   = 8'h29, AND_ABS   = 8'h2D,
      AND_IND_Y = 8'h31, AND_ZP_X = 8'h35, AND_ABS_Y = 8'h39, AND_ABS_X = 8'h3D,
      EOR_IND_X = 8'h41, EOR_ZP   = 8'h45, EOR_IMM   = 8'h49, EOR_ABS   = 8'h4D,
      EOR_IND_Y = 8'h51, EOR_ZP_X = 8'h55, EOR_ABS_Y = 8'h59, EOR_ABS_X = 8'h5D,
      ADC_IND_X = 8'h61, ADC_ZP   = 8'h65, ADC_IMM   = 8'h69, ADC_ABS   = 8'h6D,
      ADC_IND_Y = 8'h71, ADC_ZP_X = 8'h75, ADC_ABS_Y = 8'h79, ADC_ABS_X = 8'h7D,
      STA_IND_X = 8'h81, STA_ZP   = 8'h85, STA_ABS   = 8'h8D,
      STA_IND_Y = 8'h91, STA_ZP_X = 8'h95, STA_ABS_Y = 8'h99, STA_ABS_X = 8'h9D,
      LDA_IND_X = 8'hA1, LDA_ZP   = 8'hA5, LDA_IMM   = 8'hA9, LDA_ABS   = 8'hAD,
      LDA_IND_Y = 8'hB1, LDA_ZP_X = 8'hB5, LDA_ABS_Y = 8'hB9, LDA_ABS_X = 8'hBD,
      LDY_IMM   = 8'hA0,
      LDX_IMM   = 8'hA2,
      CLC       = 8'h18,
      SEC       = 8'h38,
      JMP_ABS   = 8'h4C,
      JMP_IND   = 8'h6C,
      BNE       = 8'hD0,
      BEQ       = 8'hF0
   } opcode_t;

   typedef enum logic [3:0] {
      MODE_IDLE,
      MODE_RESET,
      MODE_IMM,
      MODE_ZP,
      MODE_ZP_X,
      MODE_ABS,
      MODE_ABS_X,
      MODE_ABS_Y,
      MODE_IND_X,
      MODE_IND_Y,
      MODE_IND_ABS,
      MODE_REL
   } addr_mode_t;

   typedef enum logic [2:0] {
      ALU_PASS,
      ALU_ADC,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SEC,
      ALU_CLC
   } alu_op_t;

   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } flags_t;

   typedef struct packed {
      alu_op_t    op;
      logic [7:0] a;
      logic [7:0] b;
      logic       valid;
   } alu_req_t;

endpackage

/* hdl/m6502_bus_pkg.sv */
package m6502_bus_pkg;

   // One request per cycle; rd_req and wr_en are single-cycle strobes
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wr_data;
      logic        rd_req;
      logic        wr_en;
   } bus_req_t;

   // rd_data is valid in the first cycle after a read strobe with ready high
   typedef struct packed {
      logic [7:0] rd_data;
      logic       ready;
   } bus_rsp_t;

endpackage

/* hdl/m6502_alu.sv */
`timescale 1ns/10ps

module m6502_alu (
   input  logic                    clk,
   input  logic                    reset_n,
   input  m6502_isa_pkg::alu_req_t req,
   output logic [7:0]              result,
   output m6502_isa_pkg::flags_t   flags
);

   logic [8:0] sum;
   logic       overflow;

   assign sum = {1'b0, req.a} + {1'b0, req.b} + {8'd0, flags.c};

   // Signed overflow when both operands agree in sign and the sum does not
   assign overflow = (req.a[7] == req.b[7]) && (sum[7] != req.a[7]);

   always_comb
   begin
      case (req.op)
         m6502_isa_pkg::ALU_ADC: result = sum[7:0];
         m6502_isa_pkg::ALU_AND: result = req.a & req.b;
         m6502_isa_pkg::ALU_OR:  result = req.a | req.b;
         m6502_isa_pkg::ALU_XOR: result = req.a ^ req.b;
         default:                result = req.b;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flags <= '0;
      end
      else if (req.valid)
      begin
         case (req.op)
            m6502_isa_pkg::ALU_SEC: flags.c <= 1'b1;
            m6502_isa_pkg::ALU_CLC: flags.c <= 1'b0;
            default:
            begin
               flags.z <= (result == 8'h00);
               flags.n <= result[7];
               if (req.op == m6502_isa_pkg::ALU_ADC)
               begin
                  flags.c <= sum[8];
                  flags.v <= overflow;
               end
            end
         endcase
      end
   end

endmodule

/* hdl/m6502_addr_seq.sv */
`timescale 1ns/10ps

module m6502_addr_seq #(
   parameter logic [15:0] RESET_VECTOR = 16'hFFFC
) (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     start,
   input  m6502_isa_pkg::addr_mode_t mode,
   input  logic                     is_store,
   input  logic                     no_access,
   input  logic [7:0]               store_data,
   input  logic [15:0]              pc,
   input  logic [7:0]               ndx_x,
   input  logic [7:0]               ndx_y,
   output m6502_bus_pkg::bus_req_t  bus_req,
   input  m6502_bus_pkg::bus_rsp_t  bus_rsp,
   output logic                     done,
   output logic [7:0]               data,
   output logic [15:0]              word,
   output logic [1:0]               pc_delta
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_OP_LO,
      S_OP_HI,
      S_PTR_LO,
      S_PTR_HI,
      S_FINAL
   } step_t;

   step_t      step;
   logic       pending;
   logic [7:0] lo;
   logic [7:0] ndx;
   logic [15:0] next_addr;
   logic       to_final;
   logic       zp_ptr;

   assign zp_ptr = (mode == m6502_isa_pkg::MODE_IND_X) || (mode == m6502_isa_pkg::MODE_IND_Y);

   // Index added once the full 16-bit base is known
   always_comb
   begin
      case (mode)
         m6502_isa_pkg::MODE_ABS_X: ndx = ndx_x;
         m6502_isa_pkg::MODE_ABS_Y,
         m6502_isa_pkg::MODE_IND_Y: ndx = ndx_y;
         default:                   ndx = 8'h00;
      endcase
   end

   // Address of the next access, formed from the byte arriving this cycle
   always_comb
   begin
      case (step)
         S_OP_LO:
         begin
            case (mode)
               m6502_isa_pkg::MODE_ZP,
               m6502_isa_pkg::MODE_IND_Y: next_addr = {8'h00, bus_rsp.rd_data};
               m6502_isa_pkg::MODE_ZP_X,
               m6502_isa_pkg::MODE_IND_X: next_addr = {8'h00, bus_rsp.rd_data + ndx_x};
               default:                   next_addr = pc + 16'd1;
            endcase
         end
         S_OP_HI,
         S_PTR_HI: next_addr = {bus_rsp.rd_data, lo} + {8'h00, ndx};
         S_PTR_LO:
         begin
            // Zero page pointers wrap inside page zero
            if (zp_ptr)
               next_addr = {8'h00, bus_req.addr[7:0] + 8'd1};
            else
               next_addr = bus_req.addr + 16'd1;
         end
         default: next_addr = pc;
      endcase
   end

   always_comb
   begin
      case (step)
         S_OP_LO:  to_final = (mode == m6502_isa_pkg::MODE_ZP) ||
                              (mode == m6502_isa_pkg::MODE_ZP_X);
         S_OP_HI:  to_final = !no_access && ((mode == m6502_isa_pkg::MODE_ABS) ||
                              (mode == m6502_isa_pkg::MODE_ABS_X) ||
                              (mode == m6502_isa_pkg::MODE_ABS_Y));
         S_PTR_HI: to_final = zp_ptr;
         default:  to_final = 1'b0;
      endcase
   end

   always_comb
   begin
      case (mode)
         m6502_isa_pkg::MODE_IMM,
         m6502_isa_pkg::MODE_REL,
         m6502_isa_pkg::MODE_ZP,
         m6502_isa_pkg::MODE_ZP_X,
         m6502_isa_pkg::MODE_IND_X,
         m6502_isa_pkg::MODE_IND_Y:   pc_delta = 2'd1;
         m6502_isa_pkg::MODE_ABS,
         m6502_isa_pkg::MODE_ABS_X,
         m6502_isa_pkg::MODE_ABS_Y,
         m6502_isa_pkg::MODE_IND_ABS: pc_delta = 2'd2;
         default:                     pc_delta = 2'd0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      done          <= 1'b0;
      bus_req.wr_en <= 1'b0;
      if (!reset_n)
      begin
         step           <= S_IDLE;
         pending        <= 1'b0;
         bus_req.rd_req <= 1'b0;
      end
      else if (bus_req.rd_req)
      begin
         // Ready is not looked at in the strobe cycle itself
         bus_req.rd_req <= 1'b0;
         pending        <= 1'b1;
      end
      else if (step == S_IDLE)
      begin
         if (start)
         begin
            bus_req.addr   <= (mode == m6502_isa_pkg::MODE_RESET) ? RESET_VECTOR : pc;
            bus_req.rd_req <= 1'b1;
            case (mode)
               m6502_isa_pkg::MODE_RESET: step <= S_PTR_LO;
               m6502_isa_pkg::MODE_IMM,
               m6502_isa_pkg::MODE_REL:   step <= S_FINAL;
               default:                   step <= S_OP_LO;
            endcase
         end
      end
      else if (pending && bus_rsp.ready)
      begin
         pending <= 1'b0;
         lo      <= bus_rsp.rd_data;
         if (to_final)
         begin
            bus_req.addr <= next_addr;
            if (is_store)
            begin
               bus_req.wr_data <= store_data;
               bus_req.wr_en   <= 1'b1;
               done            <= 1'b1;
               step            <= S_IDLE;
            end
            else
            begin
               bus_req.rd_req <= 1'b1;
               step           <= S_FINAL;
            end
         end
         else
         begin
            case (step)
               S_OP_LO,
               S_PTR_LO:
               begin
                  bus_req.addr   <= next_addr;
                  bus_req.rd_req <= 1'b1;
                  if (step == S_PTR_LO)
                     step <= S_PTR_HI;
                  else
                     step <= zp_ptr ? S_PTR_LO : S_OP_HI;
               end
               S_OP_HI:
               begin
                  if (mode == m6502_isa_pkg::MODE_IND_ABS)
                  begin
                     bus_req.addr   <= next_addr;
                     bus_req.rd_req <= 1'b1;
                     step           <= S_PTR_LO;
                  end
                  else
                  begin
                     word <= next_addr;
                     done <= 1'b1;
                     step <= S_IDLE;
                  end
               end
               S_PTR_HI:
               begin
                  word <= next_addr;
                  done <= 1'b1;
                  step <= S_IDLE;
               end
               default:
               begin
                  data <= bus_rsp.rd_data;
                  done <= 1'b1;
                  step <= S_IDLE;
               end
            endcase
         end
      end
   end

   a_rd_strobe: assert property (@(posedge clk) disable iff (!reset_n)
      bus_req.rd_req |=> !bus_req.rd_req);

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!reset_n)
      !(bus_req.rd_req && bus_req.wr_en));

endmodule

/* hdl/m6502_cpu.sv */
`timescale 1ns/10ps

module m6502_cpu #(
   parameter logic [15:0] RESET_VECTOR = 16'hFFFC
) (
   input  logic                    clk,
   input  logic                    reset_n,
   output m6502_bus_pkg::bus_req_t mem_req,
   input  m6502_bus_pkg::bus_rsp_t mem_rsp
);

   typedef enum logic [2:0] {
      CPU_WAIT,
      CPU_RESET,
      CPU_FETCH,
      CPU_EXECUTE,
      CPU_EXECUTE_WAIT
   } cpu_state_t;

   typedef enum logic [1:0] {
      DST_NONE,
      DST_A,
      DST_X,
      DST_Y
   } dst_t;

   cpu_state_t                 state;
   m6502_isa_pkg::opcode_t     instr;
   logic [7:0]                 reg_a;
   logic [7:0]                 reg_x;
   logic [7:0]                 reg_y;
   logic [15:0]                pc;
   logic [15:0]                pc_next;
   logic [15:0]                fetch_addr;
   logic                       fetch_rd;
   logic                       fetch_pending;
   logic                       boot;
   logic                       issue_fetch;
   logic                       taken;

   m6502_isa_pkg::addr_mode_t  dec_mode;
   m6502_isa_pkg::addr_mode_t  seq_mode;
   m6502_isa_pkg::alu_op_t     dec_op;
   logic                       dec_store;
   logic                       dec_no_access;
   dst_t                       dec_dst;

   m6502_bus_pkg::bus_req_t    seq_req;
   logic                       seq_start;
   logic                       seq_done;
   logic                       seq_busy;
   logic [7:0]                 seq_data;
   logic [15:0]                seq_word;
   logic [1:0]                 seq_pc_delta;

   m6502_isa_pkg::alu_req_t    alu_req;
   logic [7:0]                 alu_result;
   m6502_isa_pkg::flags_t      flags;

   always_comb
   begin
      dec_mode      = m6502_isa_pkg::MODE_IDLE;
      dec_op        = m6502_isa_pkg::ALU_PASS;
      dec_store     = 1'b0;
      dec_no_access = 1'b0;
      dec_dst       = DST_NONE;
      case (instr)
         m6502_isa_pkg::LDX_IMM:
         begin
            dec_mode = m6502_isa_pkg::MODE_IMM;
            dec_dst  = DST_X;
         end
         m6502_isa_pkg::LDY_IMM:
         begin
            dec_mode = m6502_isa_pkg::MODE_IMM;
            dec_dst  = DST_Y;
         end
         m6502_isa_pkg::CLC: dec_op = m6502_isa_pkg::ALU_CLC;
         m6502_isa_pkg::SEC: dec_op = m6502_isa_pkg::ALU_SEC;
         m6502_isa_pkg::JMP_ABS:
         begin
            dec_mode      = m6502_isa_pkg::MODE_ABS;
            dec_no_access = 1'b1;
         end
         m6502_isa_pkg::JMP_IND: dec_mode = m6502_isa_pkg::MODE_IND_ABS;
         m6502_isa_pkg::BEQ,
         m6502_isa_pkg::BNE:     dec_mode = m6502_isa_pkg::MODE_REL;
         default:
         begin
            // Group one aaabbb01; CMP and SBC rows stay no-ops
            if (instr[1:0] == 2'b01 && instr[7:6] != 2'b11)
            begin
               case (instr[4:2])
                  3'd0: dec_mode = m6502_isa_pkg::MODE_IND_X;
                  3'd1: dec_mode = m6502_isa_pkg::MODE_ZP;
                  3'd2: dec_mode = m6502_isa_pkg::MODE_IMM;
                  3'd3: dec_mode = m6502_isa_pkg::MODE_ABS;
                  3'd4: dec_mode = m6502_isa_pkg::MODE_IND_Y;
                  3'd5: dec_mode = m6502_isa_pkg::MODE_ZP_X;
                  3'd6: dec_mode = m6502_isa_pkg::MODE_ABS_Y;
                  default: dec_mode = m6502_isa_pkg::MODE_ABS_X;
               endcase
               dec_dst = DST_A;
               case (instr[7:5])
                  3'b000: dec_op = m6502_isa_pkg::ALU_OR;
                  3'b001: dec_op = m6502_isa_pkg::ALU_AND;
                  3'b010: dec_op = m6502_isa_pkg::ALU_XOR;
                  3'b011: dec_op = m6502_isa_pkg::ALU_ADC;
                  3'b100:
                  begin
                     dec_store = 1'b1;
                     dec_dst   = DST_NONE;
                  end
                  default: dec_op = m6502_isa_pkg::ALU_PASS;
               endcase
               // STA immediate does not exist
               if (dec_store && dec_mode == m6502_isa_pkg::MODE_IMM)
                  dec_mode = m6502_isa_pkg::MODE_IDLE;
            end
         end
      endcase
   end

   assign seq_mode  = boot ? m6502_isa_pkg::MODE_RESET : dec_mode;
   assign seq_start = (state == CPU_RESET) ||
                      (state == CPU_EXECUTE && dec_mode != m6502_isa_pkg::MODE_IDLE);
   assign taken     = flags.z ^ (instr == m6502_isa_pkg::BNE);

   assign issue_fetch = (state == CPU_EXECUTE && dec_mode == m6502_isa_pkg::MODE_IDLE) ||
                        (state == CPU_EXECUTE_WAIT && seq_done);

   always_comb
   begin
      if (state == CPU_EXECUTE)
         pc_next = pc;
      else if (boot || dec_no_access || dec_mode == m6502_isa_pkg::MODE_IND_ABS)
         pc_next = seq_word;
      else if (dec_mode == m6502_isa_pkg::MODE_REL && taken)
         pc_next = pc + 16'd1 + {{8{seq_data[7]}}, seq_data};
      else
         pc_next = pc + {14'd0, seq_pc_delta};
   end

   always_comb
   begin
      alu_req.op    = dec_op;
      alu_req.a     = reg_a;
      alu_req.b     = seq_data;
      alu_req.valid = (state == CPU_EXECUTE && dec_mode == m6502_isa_pkg::MODE_IDLE &&
                       dec_op != m6502_isa_pkg::ALU_PASS) ||
                      (state == CPU_EXECUTE_WAIT && seq_done && !boot && dec_dst != DST_NONE);
   end

   always_ff @(posedge clk)
   begin
      fetch_rd <= 1'b0;
      if (!reset_n)
      begin
         state         <= CPU_WAIT;
         fetch_pending <= 1'b0;
         boot          <= 1'b0;
      end
      else
      begin
         case (state)
            CPU_WAIT:
            begin
               boot  <= 1'b1;
               state <= CPU_RESET;
            end
            CPU_RESET: state <= CPU_EXECUTE_WAIT;
            CPU_FETCH:
            begin
               if (fetch_rd)
               begin
                  fetch_pending <= 1'b1;
               end
               else if (fetch_pending && mem_rsp.ready)
               begin
                  fetch_pending <= 1'b0;
                  instr         <= m6502_isa_pkg::opcode_t'(mem_rsp.rd_data);
                  state         <= CPU_EXECUTE;
               end
            end
            CPU_EXECUTE:
               if (dec_mode != m6502_isa_pkg::MODE_IDLE)
                  state <= CPU_EXECUTE_WAIT;
            default: ;
         endcase
         if (issue_fetch)
         begin
            fetch_addr <= pc_next;
            fetch_rd   <= 1'b1;
            pc         <= pc_next + 16'd1;
            boot       <= 1'b0;
            state      <= CPU_FETCH;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == CPU_EXECUTE_WAIT && alu_req.valid)
      begin
         case (dec_dst)
            DST_A:   reg_a <= alu_result;
            DST_X:   reg_x <= alu_result;
            DST_Y:   reg_y <= alu_result;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         seq_busy <= 1'b0;
      else if (seq_start)
         seq_busy <= 1'b1;
      else if (seq_done)
         seq_busy <= 1'b0;
   end

   // The sequencer owns the bus for the whole of an instruction's execution
   always_comb
   begin
      if (state == CPU_EXECUTE_WAIT)
      begin
         mem_req = seq_req;
      end
      else
      begin
         mem_req.addr    = fetch_addr;
         mem_req.wr_data = 8'h00;
         mem_req.rd_req  = fetch_rd;
         mem_req.wr_en   = 1'b0;
      end
   end

   m6502_addr_seq #(
      .RESET_VECTOR(RESET_VECTOR)
   ) u_addr_seq (
      .clk       (clk),
      .reset_n   (reset_n),
      .start     (seq_start),
      .mode      (seq_mode),
      .is_store  (dec_store),
      .no_access (dec_no_access),
      .store_data(reg_a),
      .pc        (pc),
      .ndx_x     (reg_x),
      .ndx_y     (reg_y),
      .bus_req   (seq_req),
      .bus_rsp   (mem_rsp),
      .done      (seq_done),
      .data      (seq_data),
      .word      (seq_word),
      .pc_delta  (seq_pc_delta)
   );

   m6502_alu u_alu (
      .clk    (clk),
      .reset_n(reset_n),
      .req    (alu_req),
      .result (alu_result),
      .flags  (flags)
   );

   a_seq_idle_start: assert property (@(posedge clk) disable iff (!reset_n)
      seq_start |-> !seq_busy);

endmodule

/* hdl/m6502_system.sv */
`timescale 1ns/10ps

module m6502_system #(
   parameter logic [15:0] RESET_VECTOR = 16'hFFFC
) (
   input  logic                    clk,
   input  logic                    reset_n,
   output m6502_bus_pkg::bus_req_t mem_req,
   input  m6502_bus_pkg::bus_rsp_t mem_rsp
);

   // Memory is outside; the core drives the bus directly
   m6502_cpu #(
      .RESET_VECTOR(RESET_VECTOR)
   ) u_cpu (
      .clk    (clk),
      .reset_n(reset_n),
      .mem_req(mem_req),
      .mem_rsp(mem_rsp)
   );

endmodule

/* verification/m6502_tb_mem.sv */
`timescale 1ns/10ps

module m6502_tb_mem (
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic                    zero_latency,
   input  m6502_bus_pkg::bus_req_t req,
   output m6502_bus_pkg::bus_rsp_t rsp
);

   logic [7:0]  mem [0:65535];
   logic [15:0] wr_addr_q[$];
   logic [7:0]  wr_data_q[$];
   logic [15:0] rd_addr_q[$];
   integer      seed;
   int          wait_cnt;
   int          delay;

   initial
   begin
      seed = 41041;
      rsp  = '0;
   end

   // Ready drops for 0 to 2 cycles after each read strobe
   always @(posedge clk)
   begin
      if (!reset_n)
      begin
         rsp      <= '0;
         wait_cnt <= 0;
      end
      else
      begin
         if (req.rd_req)
         begin
            delay = zero_latency ? 0 : {$random(seed)} % 3;
            rsp.rd_data <= mem[req.addr];
            rsp.ready   <= (delay == 0);
            wait_cnt    <= delay;
            rd_addr_q.push_back(req.addr);
         end
         else if (wait_cnt > 0)
         begin
            wait_cnt  <= wait_cnt - 1;
            rsp.ready <= (wait_cnt == 1);
         end
         if (req.wr_en)
         begin
            mem[req.addr] <= req.wr_data;
            wr_addr_q.push_back(req.addr);
            wr_data_q.push_back(req.wr_data);
         end
      end
   end

   task automatic fill_pattern();
      logic [15:0] a;
      for (int i = 0; i < 65536; i++)
      begin
         a = i[15:0];
         mem[i] = a[7:0] ^ a[15:8] ^ 8'hA5;
      end
   endtask

   task automatic clear_logs();
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
   endtask

endmodule

/* verification/m6502_system_tb.sv */
`timescale 1ns/10ps

module m6502_system_tb;

   logic                    clk;
   logic                    reset_n;
   logic                    zero_latency;
   m6502_bus_pkg::bus_req_t mem_req;
   m6502_bus_pkg::bus_rsp_t mem_rsp;
   int                      cycles;
   integer                  seed;
   logic [15:0]             org;
   logic [15:0]             stop;
   logic [15:0]             exp_addr_q[$];
   logic [7:0]              exp_data_q[$];

   m6502_system #(
      .RESET_VECTOR(16'hFFFC)
   ) DUT (
      .clk    (clk),
      .reset_n(reset_n),
      .mem_req(mem_req),
      .mem_rsp(mem_rsp)
   );

   m6502_tb_mem mem_model (
      .clk         (clk),
      .reset_n     (reset_n),
      .zero_latency(zero_latency),
      .req         (mem_req),
      .rsp         (mem_rsp)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #5 clk = ~clk;

   // Seven short programs take well under 2000 cycles each even with the longest ready delays
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= 20000)
      begin
         $display("Timeout: the run did not finish within 20000 cycles");
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic check(input string name, input logic [15:0] expected, input logic [15:0] actual);
      if (expected !== actual)
      begin
         $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic put(input logic [7:0] b);
      mem_model.mem[org] = b;
      org = org + 16'd1;
   endtask

   task automatic put_op(input logic [7:0] op, input logic [7:0] v);
      put(op);
      put(v);
   endtask

   task automatic put_abs(input logic [7:0] op, input logic [15:0] a);
      put(op);
      put(a[7:0]);
      put(a[15:8]);
   endtask

   // New program at start with the reset vector pointing to it
   task automatic begin_program(input logic [15:0] start);
      mem_model.fill_pattern();
      mem_model.mem[16'hFFFC] = start[7:0];
      mem_model.mem[16'hFFFD] = start[15:8];
      org = start;
      exp_addr_q.delete();
      exp_data_q.delete();
   endtask

   task automatic end_program();
      stop = org;
      put_abs(m6502_isa_pkg::JMP_ABS, stop);
   endtask

   task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
      exp_addr_q.push_back(a);
      exp_data_q.push_back(d);
   endtask

   task automatic run_program();
      @(posedge clk);
      reset_n <= 1'b0;
      repeat (8) @(posedge clk);
      mem_model.clear_logs();
      reset_n <= 1'b1;
      do
         @(negedge clk);
      while (!(mem_req.rd_req && mem_req.addr == stop));
   endtask

   task automatic check_writes(input string name);
      check({name, " write count"}, exp_addr_q.size(), mem_model.wr_addr_q.size());
      for (int i = 0; i < exp_addr_q.size(); i++)
      begin
         check({name, " write addr"}, exp_addr_q[i], mem_model.wr_addr_q[i]);
         check({name, " write data"}, {8'h00, exp_data_q[i]}, {8'h00, mem_model.wr_data_q[i]});
      end
   endtask

   task automatic reset_vector_test();
      begin_program(16'h0300);
      put_op(m6502_isa_pkg::LDA_IMM, 8'h5A);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0400);
      end_program();
      expect_write(16'h0400, 8'h5A);
      run_program();
      check("reset vector lo", 16'hFFFC, mem_model.rd_addr_q[0]);
      check("reset vector hi", 16'hFFFD, mem_model.rd_addr_q[1]);
      check("first fetch", 16'h0300, mem_model.rd_addr_q[2]);
      check_writes("reset vector");
   endtask

   // Every group-one mode with X = 05 and Y = 10
   task automatic load_mode_program();
      begin_program(16'h0200);
      mem_model.mem[16'h0050] = 8'h22;
      mem_model.mem[16'h0055] = 8'h33;
      mem_model.mem[16'h1234] = 8'h44;
      mem_model.mem[16'h1235] = 8'h55;
      mem_model.mem[16'h1240] = 8'h66;
      mem_model.mem[16'h0025] = 8'h00;
      mem_model.mem[16'h0026] = 8'h15;
      mem_model.mem[16'h1500] = 8'h77;
      mem_model.mem[16'h0035] = 8'h10;
      mem_model.mem[16'h0036] = 8'h15;
      mem_model.mem[16'h0070] = 8'h00;
      mem_model.mem[16'h0071] = 8'h16;
      mem_model.mem[16'h1610] = 8'h88;
      mem_model.mem[16'h0072] = 8'h20;
      mem_model.mem[16'h0073] = 8'h16;
      mem_model.mem[16'h00FF] = 8'h00;
      mem_model.mem[16'h0000] = 8'h17;
      mem_model.mem[16'h1700] = 8'h99;
      put_op(m6502_isa_pkg::LDX_IMM, 8'h05);
      put_op(m6502_isa_pkg::LDY_IMM, 8'h10);
      put_op(m6502_isa_pkg::LDA_IMM, 8'h11);
      put_op(m6502_isa_pkg::STA_ZP, 8'h40);
      put_op(m6502_isa_pkg::LDA_ZP, 8'h50);
      put_op(m6502_isa_pkg::STA_ZP, 8'h60);
      put_op(m6502_isa_pkg::LDA_ZP_X, 8'h50);
      put_op(m6502_isa_pkg::STA_ZP_X, 8'hFE);
      put_abs(m6502_isa_pkg::LDA_ABS, 16'h1234);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h1300);
      put_abs(m6502_isa_pkg::LDA_ABS_X, 16'h1230);
      put_abs(m6502_isa_pkg::STA_ABS_X, 16'h13FE);
      put_abs(m6502_isa_pkg::LDA_ABS_Y, 16'h1230);
      put_abs(m6502_isa_pkg::STA_ABS_Y, 16'h1300);
      put_op(m6502_isa_pkg::LDA_IND_X, 8'h20);
      put_op(m6502_isa_pkg::STA_IND_X, 8'h30);
      put_op(m6502_isa_pkg::LDA_IND_Y, 8'h70);
      put_op(m6502_isa_pkg::STA_IND_Y, 8'h72);
      put_op(m6502_isa_pkg::LDA_IND_X, 8'hFA);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h1800);
      end_program();
   endtask

   task automatic addr_mode_test();
      load_mode_program();
      expect_write(16'h0040, 8'h11);
      expect_write(16'h0060, 8'h22);
      // Zero page X wraps from FE + 05 to 03
      expect_write(16'h0003, 8'h33);
      expect_write(16'h1300, 8'h44);
      expect_write(16'h13FE + 16'h0005, 8'h55);
      expect_write(16'h1300 + 16'h0010, 8'h66);
      expect_write(16'h1510, 8'h77);
      expect_write(16'h1620 + 16'h0010, 8'h88);
      expect_write(16'h1800, 8'h99);
      run_program();
      check_writes("addressing modes");
   endtask

   task automatic alu_test();
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] c;
      logic [7:0] d;
      logic [8:0] s1;
      logic [8:0] s2;
      logic [7:0] r;
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      d = $random(seed);
      begin_program(16'h0300);
      put(m6502_isa_pkg::CLC);
      put_op(m6502_isa_pkg::LDA_IMM, a);
      put_op(m6502_isa_pkg::ADC_IMM, b);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0400);
      put_op(m6502_isa_pkg::ADC_IMM, c);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0401);
      put(m6502_isa_pkg::SEC);
      put_op(m6502_isa_pkg::LDA_IMM, a);
      put_op(m6502_isa_pkg::ADC_IMM, b);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0402);
      put_op(m6502_isa_pkg::AND_IMM, c);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0403);
      put_op(m6502_isa_pkg::ORA_IMM, d);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0404);
      put_op(m6502_isa_pkg::EOR_IMM, b);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0405);
      put(m6502_isa_pkg::CLC);
      put_op(m6502_isa_pkg::LDA_IMM, 8'hF0);
      put_op(m6502_isa_pkg::ADC_IMM, 8'h20);
      put_op(m6502_isa_pkg::LDA_IMM, 8'h00);
      put_op(m6502_isa_pkg::ADC_IMM, 8'h00);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0406);
      end_program();
      s1 = {1'b0, a} + {1'b0, b};
      expect_write(16'h0400, s1[7:0]);
      s2 = {1'b0, s1[7:0]} + {1'b0, c} + {8'd0, s1[8]};
      expect_write(16'h0401, s2[7:0]);
      r = a + b + 8'd1;
      expect_write(16'h0402, r);
      r = r & c;
      expect_write(16'h0403, r);
      r = r | d;
      expect_write(16'h0404, r);
      r = r ^ b;
      expect_write(16'h0405, r);
      expect_write(16'h0406, 8'h01);
      run_program();
      check_writes("alu");
   endtask

   task automatic jump_test();
      begin_program(16'h0300);
      mem_model.mem[16'h0340] = 8'h60;
      mem_model.mem[16'h0341] = 8'h03;
      put_op(m6502_isa_pkg::LDA_IMM, 8'hA1);
      put_abs(m6502_isa_pkg::JMP_ABS, 16'h0320);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0500);
      org = 16'h0320;
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0501);
      put_abs(m6502_isa_pkg::JMP_IND, 16'h0340);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0502);
      org = 16'h0360;
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0503);
      end_program();
      expect_write(16'h0501, 8'hA1);
      expect_write(16'h0503, 8'hA1);
      run_program();
      check_writes("jumps");
   endtask

   task automatic branch_test();
      logic [15:0] loop_top;
      logic [15:0] fwd_slot;
      begin_program(16'h0300);
      mem_model.mem[16'h0080] = 8'h00;
      put_op(m6502_isa_pkg::LDA_IMM, 8'h00);
      put_op(m6502_isa_pkg::BEQ, 8'h03);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0510);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0511);
      put_op(m6502_isa_pkg::LDA_IMM, 8'h01);
      put_op(m6502_isa_pkg::BEQ, 8'h03);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0512);
      put_op(m6502_isa_pkg::BNE, 8'h03);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0513);
      // Loop runs twice and leaves by the forward BNE once 0080 holds 07
      loop_top = org;
      put_op(m6502_isa_pkg::LDA_ZP, 8'h80);
      put(m6502_isa_pkg::BNE);
      fwd_slot = org;
      put(8'h00);
      put_op(m6502_isa_pkg::LDA_IMM, 8'h07);
      put_op(m6502_isa_pkg::STA_ZP, 8'h80);
      put_abs(m6502_isa_pkg::STA_ABS, 16'h0514);
      put(m6502_isa_pkg::BNE);
      put(8'(loop_top - (org + 16'd1)));
      mem_model.mem[fwd_slot] = 8'(org - (fwd_slot + 16'd1));
      end_program();
      expect_write(16'h0511, 8'h00);
      expect_write(16'h0512, 8'h01);
      expect_write(16'h0080, 8'h07);
      expect_write(16'h0514, 8'h07);
      run_program();
      check_writes("branches");
   endtask

   task automatic latency_test();
      logic [15:0] ref_addr[$];
      logic [7:0]  ref_data[$];
      @(posedge clk);
      zero_latency <= 1'b1;
      load_mode_program();
      run_program();
      ref_addr = mem_model.wr_addr_q;
      ref_data = mem_model.wr_data_q;
      @(posedge clk);
      zero_latency <= 1'b0;
      load_mode_program();
      run_program();
      check("latency write count", ref_addr.size(), mem_model.wr_addr_q.size());
      for (int i = 0; i < ref_addr.size(); i++)
      begin
         check("latency write addr", ref_addr[i], mem_model.wr_addr_q[i]);
         check("latency write data", {8'h00, ref_data[i]}, {8'h00, mem_model.wr_data_q[i]});
      end
   endtask

   initial
   begin
      reset_n      = 1'b0;
      zero_latency = 1'b0;
      cycles       = 0;
      seed         = 41041;
      org          = 16'h0000;
      stop         = 16'h0000;
      reset_vector_test();
      addr_mode_test();
      alu_test();
      jump_test();
      branch_test();
      latency_test();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* all.f */
hdl/m6502_isa_pkg.sv
hdl/m6502_bus_pkg.sv
hdl/m6502_alu.sv
hdl/m6502_addr_seq.sv
hdl/m6502_cpu.sv
hdl/m6502_system.sv
verification/m6502_tb_mem.sv
verification/m6502_system_tb.sv

/* Makefile */
TOP = m6502_system_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No pass line in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
